// File: rtl/tmu_pix_pkg.sv
// pixel, address, burst and FML port types shared by the texture back end, imported by each stage
package tmu_pix_pkg;

	// byte address width of the external memory
	localparam int fml_depth = 26;

	// a 32-byte memory line holds sixteen RGB565 pixels
	localparam int pixels_per_burst = 16;

	// the FML port moves a line as four 64-bit beats
	localparam int beats_per_burst = 4;

	// one RGB565 pixel, red in the top five bits
	typedef logic [15:0] pixel_t;

	// destination address counted in 16-bit words, so one bit less than a byte address
	typedef logic [fml_depth-2:0] dst_adr_t;

	// address of a 32-byte line, the word address without its four slot bits
	typedef logic [fml_depth-6:0] burst_adr_t;

	// one select bit per pixel slot, the MSB stands for pixel 0 of the line
	typedef logic [pixels_per_burst-1:0] burst_sel_t;

	// sixteen pixels, pixel 0 in the top sixteen bits so that beat 0 leaves first
	typedef logic [pixels_per_burst*16-1:0] burst_data_t;

	// byte address on the FML bus
	typedef logic [fml_depth-1:0] fml_adr_t;

	// one data beat of the FML bus
	typedef logic [63:0] fml_data_t;

	// byte enables of one beat
	typedef logic [7:0] fml_sel_t;

	// decay factor, 63 leaves pixels unchanged
	typedef logic [5:0] brightness_t;

endpackage

// File: rtl/tmu_csr_pkg.sv
// CSR register map, control register fields and sequencer states of the texture back end
package tmu_csr_pkg;

	// the upper address bits select the register page of this block
	localparam int csr_page_w = 10;

	typedef logic [13:0] csr_adr_t;
	typedef logic [31:0] csr_data_t;

	// number of input pixels that make up one run
	typedef logic [23:0] pix_count_t;

	// register index, taken from the low four address bits
	typedef enum logic [3:0] {
		reg_ctl        = 4'd0,
		reg_count      = 4'd1,
		reg_brightness = 4'd2,
		reg_chroma     = 4'd3
	} csr_reg_e;

	// writing 1 here starts a run
	localparam int ctl_start_bit = 0;
	// reads back as 1 while a run is in progress
	localparam int ctl_busy_bit = 0;
	// enable of the chroma key, the key itself sits in bits 15..0
	localparam int chroma_en_bit = 16;

	// run sequencer, the flush state lasts exactly one cycle
	typedef enum logic [1:0] {
		IDLE,
		WAIT_PROCESS,
		FLUSH,
		WAIT_FLUSH
	} seq_state_e;

endpackage

// File: rtl/tmu_ctlif.sv
// CSR register file of the texture back end, holds the run settings and raises the done interrupt
module tmu_ctlif #(
	parameter logic [tmu_csr_pkg::csr_page_w-1:0] csr_addr = '0
) (
	input  logic                     sys_clk,
	input  logic                     sys_rst,

	input  tmu_csr_pkg::csr_adr_t    csr_a_i,
	input  logic                     csr_we_i,
	input  tmu_csr_pkg::csr_data_t   csr_di_i,
	output tmu_csr_pkg::csr_data_t   csr_do_o,

	output logic                     irq_o,

	input  logic                     busy_i,
	input  logic                     done_i,
	output logic                     start_o,

	output tmu_csr_pkg::pix_count_t  pix_count_o,
	output tmu_pix_pkg::brightness_t brightness_o,
	output logic                     chroma_key_en_o,
	output tmu_pix_pkg::pixel_t      chroma_key_o
);

	import tmu_csr_pkg::*;

	logic      page_sel;
	csr_reg_e  reg_sel;
	csr_data_t rd_data;

	// the page matches when the upper address bits equal the block's CSR address
	assign page_sel = (csr_a_i[$bits(csr_adr_t)-1 -: csr_page_w] == csr_addr);
	assign reg_sel  = csr_reg_e'(csr_a_i[$bits(csr_reg_e)-1:0]);

	// writes land on the same edge they are presented on
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			start_o         <= 1'b0;
			pix_count_o     <= '0;
			brightness_o    <= '1;
			chroma_key_en_o <= 1'b0;
			chroma_key_o    <= '0;
		end else begin
			// start is a single-cycle pulse following the write
			start_o <= 1'b0;
			if (page_sel && csr_we_i) begin
				case (reg_sel)
					reg_ctl:        start_o <= csr_di_i[ctl_start_bit];
					reg_count:      pix_count_o <= csr_di_i[$bits(pix_count_o)-1:0];
					reg_brightness: brightness_o <= csr_di_i[$bits(brightness_o)-1:0];
					reg_chroma: begin
						chroma_key_en_o <= csr_di_i[chroma_en_bit];
						chroma_key_o    <= csr_di_i[$bits(chroma_key_o)-1:0];
					end
					default: ;
				endcase
			end
		end
	end

	// read mux, unmapped indices return zero
	always_comb begin
		rd_data = '0;
		case (reg_sel)
			reg_ctl:        rd_data[ctl_busy_bit] = busy_i;
			reg_count:      rd_data[$bits(pix_count_o)-1:0] = pix_count_o;
			reg_brightness: rd_data[$bits(brightness_o)-1:0] = brightness_o;
			reg_chroma: begin
				rd_data[chroma_en_bit] = chroma_key_en_o;
				rd_data[$bits(chroma_key_o)-1:0] = chroma_key_o;
			end
			default: ;
		endcase
	end

	// read data is valid one cycle after the address, and zero off the page
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do_o <= '0;
			irq_o    <= 1'b0;
		end else begin
			csr_do_o <= page_sel ? rd_data : '0;
			// done comes on the last cycle of a run, so irq lines up with the return to idle
			irq_o    <= done_i;
		end
	end

endmodule

// File: rtl/tmu_decay.sv
// brightness decay stage with chroma-key dropping, two registers deep on the pixel pipeline
module tmu_decay (
	input  logic                     sys_clk,
	input  logic                     sys_rst,

	output logic                     busy_o,

	input  tmu_pix_pkg::brightness_t brightness_i,
	input  logic                     chroma_key_en_i,
	input  tmu_pix_pkg::pixel_t      chroma_key_i,

	input  logic                     pipe_stb_i,
	output logic                     pipe_ack_o,
	input  tmu_pix_pkg::pixel_t      src_pixel_i,
	input  tmu_pix_pkg::dst_adr_t    dst_adr_i,

	output logic                     pipe_stb_o,
	input  logic                     pipe_ack_i,
	output tmu_pix_pkg::pixel_t      src_pixel_o,
	output tmu_pix_pkg::dst_adr_t    dst_adr_o
);

	import tmu_pix_pkg::*;

	logic        s1_valid;
	logic        s1_ready;
	logic        s2_ready;
	logic        key_hit;
	logic [6:0]  bright_scale;
	logic [10:0] r_prod;
	logic [11:0] g_prod;
	logic [10:0] b_prod;
	dst_adr_t    s1_dst_adr;

	// a full stage moves on when the one after it is empty or being emptied
	assign s2_ready   = ~pipe_stb_o | pipe_ack_i;
	assign s1_ready   = ~s1_valid | s2_ready;
	assign pipe_ack_o = s1_ready;
	assign busy_o     = s1_valid | pipe_stb_o;

	// a keyed pixel is taken from the input but never enters stage one
	assign key_hit = chroma_key_en_i & (src_pixel_i == chroma_key_i);

	// factor runs 1..64, so each channel is scaled by (brightness + 1) / 64
	assign bright_scale = {1'b0, brightness_i} + 7'd1;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			s1_valid   <= 1'b0;
			pipe_stb_o <= 1'b0;
		end else begin
			if (s1_ready)
				s1_valid <= pipe_stb_i & ~key_hit;
			if (s2_ready)
				pipe_stb_o <= s1_valid;
		end
	end

	// stage one multiplies the three channels
	always_ff @(posedge sys_clk) begin
		if (s1_ready) begin
			r_prod     <= 11'(src_pixel_i[15:11]) * 11'(bright_scale);
			g_prod     <= 12'(src_pixel_i[10:5]) * 12'(bright_scale);
			b_prod     <= 11'(src_pixel_i[4:0]) * 11'(bright_scale);
			s1_dst_adr <= dst_adr_i;
		end
	end

	// stage two drops the six fraction bits and packs RGB565 again
	always_ff @(posedge sys_clk) begin
		if (s2_ready) begin
			src_pixel_o <= {r_prod[10:6], g_prod[11:6], b_prod[10:6]};
			dst_adr_o   <= s1_dst_adr;
		end
	end

endmodule

// File: rtl/tmu_burst.sv
// burst assembler, merges pixels of one 32-byte line and hands the line on at a line change or flush
module tmu_burst (
	input  logic                     sys_clk,
	input  logic                     sys_rst,

	input  logic                     flush_i,
	output logic                     busy_o,

	input  logic                     pipe_stb_i,
	output logic                     pipe_ack_o,
	input  tmu_pix_pkg::pixel_t      src_pixel_i,
	input  tmu_pix_pkg::dst_adr_t    dst_adr_i,

	output logic                     pipe_stb_o,
	input  logic                     pipe_ack_i,
	output tmu_pix_pkg::burst_adr_t  burst_adr_o,
	output tmu_pix_pkg::burst_sel_t  burst_sel_o,
	output tmu_pix_pkg::burst_data_t burst_do_o
);

	import tmu_pix_pkg::*;

	localparam int slot_w = $clog2(pixels_per_burst);

	// line being gathered
	burst_adr_t  cur_adr;
	burst_sel_t  cur_sel;
	burst_data_t cur_data;

	burst_adr_t        pix_line;
	logic [slot_w-1:0] pix_slot;
	burst_sel_t        slot_bit;
	logic              out_free;
	logic              take;
	logic              emit;

	// word address splits into line and slot within the line
	assign pix_line = dst_adr_i[$bits(dst_adr_t)-1:slot_w];
	assign pix_slot = dst_adr_i[slot_w-1:0];

	// pixel 0 owns the MSB of the select word
	assign slot_bit = {1'b1, {(pixels_per_burst-1){1'b0}}} >> pix_slot;

	// the output register can take a line when empty or drained this cycle
	assign out_free   = ~pipe_stb_o | pipe_ack_i;
	assign pipe_ack_o = out_free;
	assign take       = pipe_stb_i & out_free;

	// a non-empty line leaves on flush or when a pixel of another line comes in
	assign emit = (|cur_sel) & out_free & (flush_i | (pipe_stb_i & (pix_line != cur_adr)));

	assign busy_o = (|cur_sel) | pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cur_sel    <= '0;
			pipe_stb_o <= 1'b0;
		end else begin
			// an emitted line restarts with the incoming pixel, if there is one
			if (emit)
				cur_sel <= take ? slot_bit : '0;
			else if (take)
				cur_sel <= cur_sel | slot_bit;

			if (emit)
				pipe_stb_o <= 1'b1;
			else if (pipe_ack_i)
				pipe_stb_o <= 1'b0;
		end
	end

	// slots of cleared selects keep stale data, the select word masks them
	always_ff @(posedge sys_clk) begin
		if (take) begin
			// a later pixel for the same slot overwrites the earlier one
			cur_data[$bits(burst_data_t)-1 - $bits(pixel_t)*pix_slot -: $bits(pixel_t)] <=
				src_pixel_i;
			cur_adr <= pix_line;
		end
	end

	// output register sees the line as it stood before this cycle's pixel
	always_ff @(posedge sys_clk) begin
		if (emit) begin
			burst_adr_o <= cur_adr;
			burst_sel_o <= cur_sel;
			burst_do_o  <= cur_data;
		end
	end

endmodule

// File: rtl/tmu_pixout.sv
// FML write master, sends one assembled line as an address request and four data beats
module tmu_pixout (
	input  logic                     sys_clk,
	input  logic                     sys_rst,

	output logic                     busy_o,

	input  logic                     pipe_stb_i,
	output logic                     pipe_ack_o,
	input  tmu_pix_pkg::burst_adr_t  burst_adr_i,
	input  tmu_pix_pkg::burst_sel_t  burst_sel_i,
	input  tmu_pix_pkg::burst_data_t burst_do_i,

	output tmu_pix_pkg::fml_adr_t    fml_adr_o,
	output logic                     fml_stb_o,
	input  logic                     fml_ack_i,
	output tmu_pix_pkg::fml_sel_t    fml_sel_o,
	output tmu_pix_pkg::fml_data_t   fml_do_o
);

	import tmu_pix_pkg::*;

	localparam int pix_per_beat = pixels_per_burst / beats_per_burst;
	localparam int beat_w       = $clog2(beats_per_burst);

	typedef enum logic [1:0] {
		PO_IDLE,
		PO_REQ,
		PO_DATA
	} po_state_e;

	po_state_e               state;
	logic [beat_w-1:0]       beat_cnt;
	logic [pix_per_beat-1:0] beat_sel;
	burst_adr_t              adr_r;
	burst_sel_t              sel_r;
	burst_data_t             data_r;

	// a new line is only taken between writes
	assign pipe_ack_o = (state == PO_IDLE);
	assign busy_o     = (state != PO_IDLE);
	assign fml_stb_o  = (state == PO_REQ);

	// line number times 32 gives the byte address
	assign fml_adr_o = {adr_r, {(fml_depth-$bits(burst_adr_t)){1'b0}}};

	// beat n carries pixels 4n..4n+3, the first of them in the top field
	assign fml_do_o = data_r[$bits(burst_data_t)-1 - $bits(fml_data_t)*beat_cnt -: $bits(fml_data_t)];
	assign beat_sel = sel_r[pixels_per_burst-1 - pix_per_beat*beat_cnt -: pix_per_beat];

	// every selected pixel enables both of its bytes
	always_comb begin
		for (int i = 0; i < pix_per_beat; i++)
			fml_sel_o[2*i +: 2] = {2{beat_sel[i]}};
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= PO_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				PO_IDLE: if (pipe_stb_i) state <= PO_REQ;
				// beats start on the cycle after the ack and run back to back
				PO_REQ: if (fml_ack_i) begin
					state    <= PO_DATA;
					beat_cnt <= '0;
				end
				PO_DATA: begin
					beat_cnt <= beat_cnt + 1'b1;
					if (beat_cnt == beat_w'(beats_per_burst - 1))
						state <= PO_IDLE;
				end
				default: state <= PO_IDLE;
			endcase
		end
	end

	// the line is held here for the whole write, freeing the assembler early
	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o) begin
			adr_r  <= burst_adr_i;
			sel_r  <= burst_sel_i;
			data_r <= burst_do_i;
		end
	end

endmodule

// File: rtl/tmu_backend.sv
// top level of the texture back end that counts input pixels and sequences run, flush and interrupt
module tmu_backend #(
	parameter logic [tmu_csr_pkg::csr_page_w-1:0] csr_addr = '0
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst,

	input  tmu_csr_pkg::csr_adr_t  csr_a_i,
	input  logic                   csr_we_i,
	input  tmu_csr_pkg::csr_data_t csr_di_i,
	output tmu_csr_pkg::csr_data_t csr_do_o,
	output logic                   irq_o,

	input  logic                   pix_stb_i,
	output logic                   pix_ack_o,
	input  tmu_pix_pkg::pixel_t    pix_src_i,
	input  tmu_pix_pkg::dst_adr_t  pix_dst_adr_i,

	output tmu_pix_pkg::fml_adr_t  fml_adr_o,
	output logic                   fml_stb_o,
	input  logic                   fml_ack_i,
	output tmu_pix_pkg::fml_sel_t  fml_sel_o,
	output tmu_pix_pkg::fml_data_t fml_do_o
);

	import tmu_pix_pkg::*;
	import tmu_csr_pkg::*;

	logic        start, busy, done, flush;
	pix_count_t  pix_count;
	brightness_t brightness;
	logic        chroma_key_en;
	pixel_t      chroma_key;

	logic        decay_busy, decay_ack, decay_stb, decay_out_ack;
	pixel_t      decay_pixel;
	dst_adr_t    decay_dst_adr;

	logic        burst_busy, burst_stb, burst_ack;
	burst_adr_t  burst_adr;
	burst_sel_t  burst_sel;
	burst_data_t burst_data;
	logic        pixout_busy;

	pix_count_t  pix_cnt;
	logic        count_reached, pix_gate, pipeline_busy, stream_busy;
	seq_state_e  state, next_state;

	tmu_ctlif #(.csr_addr(csr_addr)) i_ctlif (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a_i(csr_a_i), .csr_we_i(csr_we_i), .csr_di_i(csr_di_i), .csr_do_o(csr_do_o),
		.irq_o(irq_o), .busy_i(busy), .done_i(done), .start_o(start),
		.pix_count_o(pix_count), .brightness_o(brightness),
		.chroma_key_en_o(chroma_key_en), .chroma_key_o(chroma_key)
	);

	// the stream is only offered downstream while the run still wants pixels
	assign count_reached = (pix_cnt == pix_count);
	assign pix_gate      = (state == WAIT_PROCESS) & ~count_reached;
	assign pix_ack_o     = pix_gate & decay_ack;

	tmu_decay i_decay (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .busy_o(decay_busy),
		.brightness_i(brightness), .chroma_key_en_i(chroma_key_en), .chroma_key_i(chroma_key),
		.pipe_stb_i(pix_stb_i & pix_gate), .pipe_ack_o(decay_ack),
		.src_pixel_i(pix_src_i), .dst_adr_i(pix_dst_adr_i),
		.pipe_stb_o(decay_stb), .pipe_ack_i(decay_out_ack),
		.src_pixel_o(decay_pixel), .dst_adr_o(decay_dst_adr)
	);

	tmu_burst i_burst (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .flush_i(flush), .busy_o(burst_busy),
		.pipe_stb_i(decay_stb), .pipe_ack_o(decay_out_ack),
		.src_pixel_i(decay_pixel), .dst_adr_i(decay_dst_adr),
		.pipe_stb_o(burst_stb), .pipe_ack_i(burst_ack),
		.burst_adr_o(burst_adr), .burst_sel_o(burst_sel), .burst_do_o(burst_data)
	);

	tmu_pixout i_pixout (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .busy_o(pixout_busy),
		.pipe_stb_i(burst_stb), .pipe_ack_o(burst_ack),
		.burst_adr_i(burst_adr), .burst_sel_i(burst_sel), .burst_do_i(burst_data),
		.fml_adr_o(fml_adr_o), .fml_stb_o(fml_stb_o), .fml_ack_i(fml_ack_i),
		.fml_sel_o(fml_sel_o), .fml_do_o(fml_do_o)
	);

	assign pipeline_busy = decay_busy | burst_busy | pixout_busy;

	// the last line waits in the assembler until the flush, so only its output register counts here
	assign stream_busy   = decay_busy | burst_stb | pixout_busy;

	// the count of accepted pixels includes dropped ones and restarts from zero at each run
	always_ff @(posedge sys_clk) begin
		if (sys_rst || start)
			pix_cnt <= '0;
		else if (pix_stb_i && pix_ack_o)
			pix_cnt <= pix_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	// busy follows the registered state, so it rises one cycle after start
	always_comb begin
		next_state = state;
		busy       = (state != IDLE);
		flush      = 1'b0;
		done       = 1'b0;
		case (state)
			IDLE: if (start) next_state = WAIT_PROCESS;
			WAIT_PROCESS: if (count_reached && !stream_busy) next_state = FLUSH;
			FLUSH: begin
				flush      = 1'b1;
				next_state = WAIT_FLUSH;
			end
			// the last line leaves the assembler here and has to reach memory first
			WAIT_FLUSH: if (!pipeline_busy) begin
				next_state = IDLE;
				done       = 1'b1;
			end
			default: next_state = IDLE;
		endcase
	end

endmodule

// File: bench/tmu_backend_tb.sv
// testbench for the texture back end, runs a table of pixel streams and checks every FML write
module tmu_backend_tb;

	import tmu_pix_pkg::*;
	import tmu_csr_pkg::*;

	localparam logic [csr_page_w-1:0] csr_page = 10'h2a7;
	localparam int num_rows     = 6;
	localparam int reset_cycles = 16;

	// stimulus table, one run per row, the pixel lists live in stim_pix and stim_adr
	string       row_name   [num_rows] = '{"one_line_full", "half_brightness", "chroma_key_on",
		"chroma_key_off", "three_lines", "random_ack_stream"};
	brightness_t row_bright [num_rows] = '{6'd63, 6'd31, 6'd63, 6'd63, 6'd63, 6'd45};
	csr_data_t   row_chroma [num_rows] = '{32'h0, 32'h0, 32'h1_f800, 32'h0_f800, 32'h0, 32'h0};
	int          row_first  [num_rows];
	int          row_len    [num_rows];

	pixel_t   stim_pix [$];
	dst_adr_t stim_adr [$];

	// expected writes, one address and four beats per burst
	fml_adr_t  exp_adr  [$];
	fml_data_t exp_data [$];
	fml_sel_t  exp_sel  [$];

	// reference line being gathered, bit k of model_sel stands for pixel k
	pixel_t                      model_pix [pixels_per_burst];
	logic [pixels_per_burst-1:0] model_sel;

	logic      sys_clk;
	logic      sys_rst;
	csr_adr_t  csr_a_i;
	logic      csr_we_i;
	csr_data_t csr_di_i;
	csr_data_t csr_do_o;
	logic      irq_o;
	logic      pix_stb_i;
	logic      pix_ack_o;
	pixel_t    pix_src_i;
	dst_adr_t  pix_dst_adr_i;
	fml_adr_t  fml_adr_o;
	logic      fml_stb_o;
	logic      fml_ack_i;
	fml_sel_t  fml_sel_o;
	fml_data_t fml_do_o;

	string test_name;
	int    irq_count;

	tmu_backend #(.csr_addr(csr_page)) i_tmu_backend (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a_i(csr_a_i), .csr_we_i(csr_we_i), .csr_di_i(csr_di_i), .csr_do_o(csr_do_o),
		.irq_o(irq_o),
		.pix_stb_i(pix_stb_i), .pix_ack_o(pix_ack_o),
		.pix_src_i(pix_src_i), .pix_dst_adr_i(pix_dst_adr_i),
		.fml_adr_o(fml_adr_o), .fml_stb_o(fml_stb_o), .fml_ack_i(fml_ack_i),
		.fml_sel_o(fml_sel_o), .fml_do_o(fml_do_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_adr(input fml_adr_t expected, input fml_adr_t actual);
		if (actual !== expected)
			report_failure($sformatf("MISMATCH %s fml address: expected %h, actual %h",
				test_name, expected, actual));
	endtask

	// only enabled bytes carry defined data, so the compare is masked by the expected enables
	task automatic check_beat(input int beat, input fml_data_t exp_d, input fml_sel_t exp_s,
			input fml_data_t act_d, input fml_sel_t act_s);
		fml_data_t mask;
		for (int i = 0; i < $bits(fml_sel_t); i++)
			mask[8*i +: 8] = {8{exp_s[i]}};
		if (act_s !== exp_s)
			report_failure($sformatf("MISMATCH %s beat %0d byte enables: expected %h, actual %h",
				test_name, beat, exp_s, act_s));
		else if ((act_d & mask) !== (exp_d & mask))
			report_failure($sformatf("MISMATCH %s beat %0d data: expected %h, actual %h",
				test_name, beat, exp_d & mask, act_d & mask));
	endtask

	task automatic check_csr(input csr_data_t expected, input csr_data_t actual);
		if (actual !== expected)
			report_failure($sformatf("MISMATCH %s csr read: expected %h, actual %h",
				test_name, expected, actual));
	endtask

	task automatic check_irq(input int expected, input int actual);
		if (actual != expected)
			report_failure($sformatf("MISMATCH %s irq cycles: expected %0d, actual %0d",
				test_name, expected, actual));
	endtask

	// each channel times (brightness + 1), then the six fraction bits are dropped
	function automatic pixel_t scale_pixel(input pixel_t p, input brightness_t b);
		int f;
		int r;
		int g;
		int bl;
		f  = int'(b) + 1;
		r  = (int'(p[15:11]) * f) / 64;
		g  = (int'(p[10:5]) * f) / 64;
		bl = (int'(p[4:0]) * f) / 64;
		return {r[4:0], g[5:0], bl[4:0]};
	endfunction

	// pixel k goes to beat k/4, field 3 - k%4, with both of its bytes enabled
	task automatic push_line(input burst_adr_t line);
		fml_data_t d;
		fml_sel_t  s;
		int        k;
		exp_adr.push_back(fml_adr_t'(line) << 5);
		for (int n = 0; n < beats_per_burst; n++) begin
			d = '0;
			s = '0;
			for (int m = 0; m < 4; m++) begin
				k = 4 * n + m;
				if (model_sel[k]) begin
					d[16*(3-m) +: 16] = model_pix[k];
					s[2*(3-m) +: 2]   = 2'b11;
				end
			end
			exp_data.push_back(d);
			exp_sel.push_back(s);
		end
	endtask

	task automatic build_expected(input int row);
		logic       key_on;
		burst_adr_t line;
		burst_adr_t cur_line;
		int         slot;
		key_on    = row_chroma[row][chroma_en_bit];
		model_sel = '0;
		cur_line  = '0;
		for (int i = row_first[row]; i < row_first[row] + row_len[row]; i++) begin
			// a keyed pixel is counted but never written
			if (!(key_on && stim_pix[i] == row_chroma[row][15:0])) begin
				line = burst_adr_t'(stim_adr[i] >> 4);
				slot = int'(stim_adr[i][3:0]);
				if (model_sel != 0 && line != cur_line) begin
					push_line(cur_line);
					model_sel = '0;
				end
				cur_line        = line;
				model_pix[slot] = scale_pixel(stim_pix[i], row_bright[row]);
				model_sel[slot] = 1'b1;
			end
		end
		// whatever is left goes out with the flush at the end of the run
		if (model_sel != 0)
			push_line(cur_line);
	endtask

	task automatic add_pixel(input pixel_t p, input dst_adr_t a);
		stim_pix.push_back(p);
		stim_adr.push_back(a);
	endtask

	task automatic build_stimulus();
		row_first[0] = stim_pix.size();
		for (int i = 0; i < 16; i++)
			add_pixel(16'h1234 + 16'h0f31 * i, {21'h00123, 4'(i)});
		row_len[0] = 16;
		row_first[1] = stim_pix.size();
		for (int i = 0; i < 8; i++)
			add_pixel(16'($urandom), {21'h00040, 4'(2 * i + 1)});
		row_len[1] = 8;
		// every third pixel carries the key colour
		row_first[2] = stim_pix.size();
		for (int i = 0; i < 8; i++)
			add_pixel((i % 3 == 0) ? 16'hf800 : 16'($urandom), {21'h00077, 4'(i)});
		row_len[2] = 8;
		row_first[3] = row_first[2];
		row_len[3]   = 8;
		// three lines, with slot 15 of the middle one written twice
		row_first[4] = stim_pix.size();
		add_pixel(16'hffff, {21'h00300, 4'd5});
		add_pixel(16'h07e0, {21'h00300, 4'd1});
		add_pixel(16'h001f, {21'h00012, 4'd15});
		add_pixel(16'h8410, {21'h00012, 4'd0});
		add_pixel(16'hc618, {21'h00012, 4'd15});
		add_pixel(16'h39e7, {21'h1ffff, 4'd7});
		add_pixel(16'ha5a5, {21'h1ffff, 4'd3});
		row_len[4] = 7;
		row_first[5] = stim_pix.size();
		for (int i = 0; i < 24; i++)
			add_pixel(16'($urandom),
				{21'h00200 + 21'($urandom_range(3, 0)), 4'($urandom_range(15, 0))});
		row_len[5] = 24;
	endtask

	task automatic write_reg(input csr_reg_e idx, input csr_data_t data);
		csr_a_i  = {csr_page, idx};
		csr_we_i = 1'b1;
		csr_di_i = data;
		@(posedge sys_clk);
		#1;
		csr_we_i = 1'b0;
	endtask

	// read data is registered, so it is taken one edge after the address
	task automatic read_reg(input csr_reg_e idx, output csr_data_t data);
		csr_a_i  = {csr_page, idx};
		csr_we_i = 1'b0;
		@(posedge sys_clk);
		#1;
		data = csr_do_o;
	endtask

	// ack is sampled mid cycle, the transfer completes on the following edge
	task automatic send_pixel(input pixel_t p, input dst_adr_t a);
		logic taken;
		pix_stb_i     = 1'b1;
		pix_src_i     = p;
		pix_dst_adr_i = a;
		taken         = 1'b0;
		while (!taken) begin
			#3;
			taken = pix_ack_o;
			@(posedge sys_clk);
			#1;
		end
		pix_stb_i = 1'b0;
	endtask

	// FML slave that acks after a random wait and checks the address and four beats
	initial begin
		int delay;
		fml_ack_i = 1'b0;
		forever begin
			@(posedge sys_clk);
			#1;
			if (fml_stb_o) begin
				delay = $urandom_range(5, 0);
				repeat (delay) begin
					@(posedge sys_clk);
					#1;
				end
				if (exp_adr.size() == 0)
					report_failure($sformatf("%s: FML write to %h that the test does not expect",
						test_name, fml_adr_o));
				check_adr(exp_adr.pop_front(), fml_adr_o);
				fml_ack_i = 1'b1;
				@(posedge sys_clk);
				#1;
				fml_ack_i = 1'b0;
				// beats run back to back from the cycle after the ack
				for (int b = 0; b < beats_per_burst; b++) begin
					if (b > 0) begin
						@(posedge sys_clk);
						#1;
					end
					if (fml_stb_o)
						report_failure($sformatf("%s: FML strobe raised during data beats", test_name));
					check_beat(b, exp_data.pop_front(), exp_sel.pop_front(), fml_do_o, fml_sel_o);
				end
			end
		end
	end

	// counts every cycle with irq high, so a pulse longer than one cycle shows up
	initial begin
		irq_count = 0;
		forever begin
			@(posedge sys_clk);
			#4;
			if (irq_o)
				irq_count++;
		end
	end

	initial begin
		repeat (reset_cycles + 400 * num_rows) @(posedge sys_clk);
		report_failure("watchdog expired before all runs finished");
	end

	initial begin
		int        done_before;
		csr_data_t rd;
		void'($urandom(97));
		sys_rst       = 1'b1;
		csr_a_i       = '0;
		csr_we_i      = 1'b0;
		csr_di_i      = '0;
		pix_stb_i     = 1'b0;
		pix_src_i     = '0;
		pix_dst_adr_i = '0;
		test_name     = "reset";
		build_stimulus();
		repeat (reset_cycles) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		for (int row = 0; row < num_rows; row++) begin
			test_name = row_name[row];
			build_expected(row);
			write_reg(reg_count, csr_data_t'(row_len[row]));
			write_reg(reg_brightness, csr_data_t'(row_bright[row]));
			write_reg(reg_chroma, row_chroma[row]);
			read_reg(reg_count, rd);
			check_csr(csr_data_t'(row_len[row]), rd);
			read_reg(reg_brightness, rd);
			check_csr(csr_data_t'(row_bright[row]), rd);
			read_reg(reg_chroma, rd);
			check_csr(row_chroma[row], rd);
			done_before = irq_count;
			write_reg(reg_ctl, 32'h1);
			// start pulses one cycle after the write and busy follows a cycle later
			@(posedge sys_clk);
			#1;
			read_reg(reg_ctl, rd);
			check_csr(32'h1, rd);
			for (int i = row_first[row]; i < row_first[row] + row_len[row]; i++)
				send_pixel(stim_pix[i], stim_adr[i]);
			// a spare pixel stays offered, the count is reached so it is never taken
			pix_stb_i     = 1'b1;
			pix_src_i     = 16'hffff;
			pix_dst_adr_i = '0;
			while (irq_count == done_before) begin
				#3;
				if (pix_ack_o)
					report_failure($sformatf("%s: pixel accepted after the count", test_name));
				@(posedge sys_clk);
				#1;
			end
			pix_stb_i = 1'b0;
			// a few more cycles so that a stretched or repeated irq is counted too
			repeat (4) begin
				@(posedge sys_clk);
				#1;
			end
			check_irq(done_before + 1, irq_count);
			read_reg(reg_ctl, rd);
			check_csr(32'h0, rd);
			if (exp_adr.size() != 0)
				report_failure($sformatf("%s: %0d expected FML writes never arrived",
					test_name, exp_adr.size()));
		end
		$display("All checks passed");
		$finish;
	end

endmodule

// File: flist.f
rtl/tmu_pix_pkg.sv
rtl/tmu_csr_pkg.sv
rtl/tmu_ctlif.sv
rtl/tmu_decay.sv
rtl/tmu_burst.sv
rtl/tmu_pixout.sv
rtl/tmu_backend.sv
bench/tmu_backend_tb.sv

// File: Bender.yml
package:
  name: tmu_backend

sources:
  - rtl/tmu_pix_pkg.sv
  - rtl/tmu_csr_pkg.sv
  - rtl/tmu_ctlif.sv
  - rtl/tmu_decay.sv
  - rtl/tmu_burst.sv
  - rtl/tmu_pixout.sv
  - rtl/tmu_backend.sv
  - target: test
    files:
      - bench/tmu_backend_tb.sv
